// ==== hw/dbg_pkg.sv ====
package dbg_pkg;

    // Widths and depths
    localparam int NB_DATA      = 8;
    localparam int NB_WORD      = 32;
    localparam int NB_IMEM_ADDR = 6;    // 64 instruction words
    localparam int NB_RB_ADDR   = 5;
    localparam int RB_DEPTH     = 32;
    localparam int NB_DM_ADDR   = 7;
    localparam int DM_DEPTH     = 128;
    localparam int N_LANES      = 4;    // Byte lanes per instruction word

    // Host command bytes
    localparam logic [NB_DATA-1:0] CMD_LOAD    = 8'd1;
    localparam logic [NB_DATA-1:0] CMD_RUN     = 8'd2;
    localparam logic [NB_DATA-1:0] CMD_STEP    = 8'd3;
    localparam logic [NB_DATA-1:0] CMD_DUMP_RB = 8'd6;
    localparam logic [NB_DATA-1:0] CMD_SEND_PC = 8'd7;
    localparam logic [NB_DATA-1:0] CMD_DUMP_DM = 8'd8;

    // Core opcodes where anything else is a no-op
    localparam logic [NB_DATA-1:0] OP_LI   = 8'h01;
    localparam logic [NB_DATA-1:0] OP_SB   = 8'h02;
    localparam logic [NB_DATA-1:0] OP_HALT = 8'hFF;

    // Decoded fields for the core and byte lanes for assembly at the top
    typedef union packed {
        struct packed {
            logic [NB_DATA-1:0]    opcode;
            logic [2:0]            unused;
            logic [NB_RB_ADDR-1:0] rd;
            logic [15:0]           imm;
        } fields;
        logic [0:N_LANES-1][NB_DATA-1:0] bytes;   // Byte 0 is the MSB
    } inst_word_t;

endpackage

// ==== hw/imem_wr_if.sv ====
`timescale 1ns/1ns

interface imem_wr_if;

    logic [dbg_pkg::NB_IMEM_ADDR-1:0] addr;       // Word address
    logic [dbg_pkg::N_LANES-1:0]      lane_sel;   // One hot
    logic [dbg_pkg::NB_DATA-1:0]      data;
    logic                             write;      // Single cycle strobe

    modport loader (
        output addr,
        output lane_sel,
        output data,
        output write
    );

    modport lane (
        input addr,
        input lane_sel,
        input data,
        input write
    );

endinterface

// ==== hw/imem_lane.sv ====
`timescale 1ns/1ns

module imem_lane #(
    parameter int IMEM_DEPTH = 64,
    parameter int LANE       = 0
) (
    input  logic                             i_clock,
    imem_wr_if.lane                          wr,
    input  logic [dbg_pkg::NB_IMEM_ADDR-1:0] i_rd_addr,
    output logic [dbg_pkg::NB_DATA-1:0]      o_rd_data
);

    logic [dbg_pkg::NB_DATA-1:0] mem [IMEM_DEPTH];

    // Program load writes only the bytes addressed to this lane
    always_ff @(posedge i_clock) begin
        if (wr.write && wr.lane_sel[LANE]) begin
            mem[wr.addr] <= wr.data;
        end
    end

    always_ff @(posedge i_clock) begin
        o_rd_data <= mem[i_rd_addr];    // Fetch data one cycle later
    end

endmodule

// ==== hw/reg_bank.sv ====
`timescale 1ns/1ns

module reg_bank (
    input  logic                           i_clock,
    input  logic                           i_wr_en,
    input  logic [dbg_pkg::NB_RB_ADDR-1:0] i_wr_addr,
    input  logic [dbg_pkg::NB_WORD-1:0]    i_wr_data,
    input  logic [dbg_pkg::NB_RB_ADDR-1:0] i_rd_addr,
    output logic [dbg_pkg::NB_WORD-1:0]    o_rd_data,
    input  logic [dbg_pkg::NB_RB_ADDR-1:0] i_dbg_addr,
    output logic [dbg_pkg::NB_WORD-1:0]    o_dbg_data
);

    logic [dbg_pkg::NB_WORD-1:0] regs [dbg_pkg::RB_DEPTH];

    always_ff @(posedge i_clock) begin
        if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Core and debug ports read independently
    always_ff @(posedge i_clock) begin
        o_rd_data  <= regs[i_rd_addr];
        o_dbg_data <= regs[i_dbg_addr];
    end

endmodule

// ==== hw/data_mem.sv ====
`timescale 1ns/1ns

module data_mem (
    input  logic                           i_clock,
    input  logic                           i_wr_en,
    input  logic [dbg_pkg::NB_DM_ADDR-1:0] i_wr_addr,
    input  logic [dbg_pkg::NB_DATA-1:0]    i_wr_data,
    input  logic [dbg_pkg::NB_DM_ADDR-1:0] i_dbg_addr,
    output logic [dbg_pkg::NB_DATA-1:0]    o_dbg_data
);

    logic [dbg_pkg::NB_DATA-1:0] mem [dbg_pkg::DM_DEPTH];

    // Byte stores from the core
    always_ff @(posedge i_clock) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clock) begin
        o_dbg_data <= mem[i_dbg_addr];
    end

endmodule

// ==== hw/exec_core.sv ====
`timescale 1ns/1ns

module exec_core #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_run,
    input  logic                             i_step,
    input  logic                             i_restart,
    input  dbg_pkg::inst_word_t              i_inst,
    output logic [dbg_pkg::NB_IMEM_ADDR-1:0] o_fetch_addr,
    output logic [dbg_pkg::NB_RB_ADDR-1:0]   o_rb_rd_addr,
    input  logic [dbg_pkg::NB_WORD-1:0]      i_rb_rd_data,
    output logic                             o_rb_wr_en,
    output logic [dbg_pkg::NB_RB_ADDR-1:0]   o_rb_wr_addr,
    output logic [dbg_pkg::NB_WORD-1:0]      o_rb_wr_data,
    output logic                             o_dm_wr_en,
    output logic [dbg_pkg::NB_DM_ADDR-1:0]   o_dm_wr_addr,
    output logic [dbg_pkg::NB_DATA-1:0]      o_dm_wr_data,
    output logic [dbg_pkg::NB_IMEM_ADDR-1:0] o_pc,
    output logic                             o_halted
);

    logic                             exec_q;     // Low is fetch, high is execute
    logic                             halted_q;
    logic [dbg_pkg::NB_IMEM_ADDR-1:0] pc_q;
    logic [dbg_pkg::NB_IMEM_ADDR-1:0] pc_next;
    logic                             is_halt;

    assign is_halt = exec_q && (i_inst.fields.opcode == dbg_pkg::OP_HALT);

    // The lanes are always addressed with the PC of the next cycle,
    // so i_inst holds the word at the current PC in both states
    always_comb begin
        pc_next = pc_q;
        if (i_restart) begin
            pc_next = '0;
        end else if (exec_q && !is_halt) begin
            pc_next = (pc_q == IMEM_DEPTH - 1) ? '0 : pc_q + 1'b1;   // Wrap at depth
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            exec_q   <= 1'b0;
            halted_q <= 1'b0;
            pc_q     <= '0;
        end else begin
            pc_q <= pc_next;
            if (i_restart) begin
                exec_q   <= 1'b0;
                halted_q <= 1'b0;
            end else if (exec_q) begin
                exec_q <= 1'b0;
                if (is_halt) begin
                    halted_q <= 1'b1;   // PC stays on the halt
                end
            end else if ((i_run || i_step) && !halted_q) begin
                exec_q <= 1'b1;
            end
        end
    end

    assign o_fetch_addr = pc_next;

    // Register read issued in fetch, used by a store in execute
    assign o_rb_rd_addr = i_inst.fields.rd;

    // Load immediate
    assign o_rb_wr_en   = exec_q && (i_inst.fields.opcode == dbg_pkg::OP_LI);
    assign o_rb_wr_addr = i_inst.fields.rd;
    assign o_rb_wr_data = {16'b0, i_inst.fields.imm};

    // Store byte
    assign o_dm_wr_en   = exec_q && (i_inst.fields.opcode == dbg_pkg::OP_SB);
    assign o_dm_wr_addr = i_inst.fields.imm[dbg_pkg::NB_DM_ADDR-1:0];
    assign o_dm_wr_data = i_rb_rd_data[dbg_pkg::NB_DATA-1:0];

    assign o_pc     = pc_q;
    assign o_halted = halted_q;

endmodule

// ==== hw/debug_unit.sv ====
`timescale 1ns/1ns

module debug_unit #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_rx_done,
    input  logic [dbg_pkg::NB_DATA-1:0]      i_rx_data,
    input  logic                             i_tx_done,
    output logic                             o_tx_start,
    output logic [dbg_pkg::NB_DATA-1:0]      o_tx_data,
    imem_wr_if.loader                        imem,
    output logic                             o_core_run,
    output logic                             o_core_step,
    output logic                             o_core_restart,
    input  logic                             i_halted,
    input  logic [dbg_pkg::NB_IMEM_ADDR-1:0] i_pc,
    output logic [dbg_pkg::NB_RB_ADDR-1:0]   o_rb_addr,
    input  logic [dbg_pkg::NB_WORD-1:0]      i_rb_data,
    output logic [dbg_pkg::NB_DM_ADDR-1:0]   o_dm_addr,
    input  logic [dbg_pkg::NB_DATA-1:0]      i_dm_data
);

    localparam int NB_SIZE    = 16;
    localparam int IMEM_BYTES = IMEM_DEPTH * dbg_pkg::N_LANES;

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_SIZE_HI = 3'd1;
    localparam logic [2:0] S_SIZE_LO = 3'd2;
    localparam logic [2:0] S_LOAD    = 3'd3;
    localparam logic [2:0] S_RUN     = 3'd4;
    localparam logic [2:0] S_READ    = 3'd5;  // Sync read in flight
    localparam logic [2:0] S_START   = 3'd6;
    localparam logic [2:0] S_WAIT_TX = 3'd7;

    // What a dump is sending
    localparam logic [1:0] SEL_PC = 2'd0;
    localparam logic [1:0] SEL_RB = 2'd1;
    localparam logic [1:0] SEL_DM = 2'd2;

    logic [2:0]                     state;
    logic [1:0]                     dump_sel;
    logic [NB_SIZE-1:0]             size;
    logic [NB_SIZE-1:0]             byte_idx;
    logic [1:0]                     byte_pos;     // Byte within the word from the MSB down
    logic [dbg_pkg::NB_RB_ADDR-1:0] rb_idx;
    logic [dbg_pkg::NB_DM_ADDR-1:0] dm_addr;
    logic [dbg_pkg::NB_WORD-1:0]    src_word;
    logic [dbg_pkg::NB_DATA-1:0]    tx_byte;
    logic                           last_byte;
    logic                           last_item;

    always_comb begin
        if (dump_sel == SEL_PC) begin
            src_word = {{(dbg_pkg::NB_WORD - dbg_pkg::NB_IMEM_ADDR){1'b0}}, i_pc};
        end else begin
            src_word = i_rb_data;
        end
        tx_byte = src_word[dbg_pkg::NB_WORD - 1 - byte_pos * dbg_pkg::NB_DATA -: dbg_pkg::NB_DATA];
        if (dump_sel == SEL_DM) begin
            tx_byte = i_dm_data;    // One byte per address
        end
    end

    always_comb begin
        last_byte = (dump_sel == SEL_DM) || (byte_pos == 2'd3);
        case (dump_sel)
            SEL_RB:  last_item = (rb_idx == dbg_pkg::RB_DEPTH - 1);
            SEL_DM:  last_item = (dm_addr == dbg_pkg::DM_DEPTH - 1);
            default: last_item = 1'b1;
        endcase
    end

    always_ff @(posedge i_clock) begin
        o_tx_start     <= 1'b0;
        o_core_step    <= 1'b0;
        o_core_restart <= 1'b0;
        imem.write     <= 1'b0;
        if (i_reset) begin
            state    <= S_IDLE;
            dump_sel <= SEL_PC;
            size     <= '0;
            byte_idx <= '0;
            byte_pos <= '0;
            rb_idx   <= '0;
            dm_addr  <= '0;
        end else begin
            case (state)
                S_IDLE: if (i_rx_done) begin
                    byte_pos <= '0;
                    rb_idx   <= '0;
                    dm_addr  <= '0;
                    case (i_rx_data)
                        dbg_pkg::CMD_LOAD:    state <= S_SIZE_HI;
                        dbg_pkg::CMD_RUN:     state <= S_RUN;
                        dbg_pkg::CMD_STEP:    o_core_step <= 1'b1;
                        dbg_pkg::CMD_DUMP_RB: begin
                            dump_sel <= SEL_RB;
                            state    <= S_READ;
                        end
                        dbg_pkg::CMD_SEND_PC: begin
                            dump_sel <= SEL_PC;
                            state    <= S_READ;
                        end
                        dbg_pkg::CMD_DUMP_DM: begin
                            dump_sel <= SEL_DM;
                            state    <= S_READ;
                        end
                        default: state <= S_IDLE;   // Unknown byte dropped
                    endcase
                end
                S_SIZE_HI: if (i_rx_done) begin
                    size[NB_SIZE-1:8] <= i_rx_data;
                    state             <= S_SIZE_LO;
                end
                S_SIZE_LO: if (i_rx_done) begin
                    size[7:0] <= i_rx_data;
                    byte_idx  <= '0;
                    if ({size[NB_SIZE-1:8], i_rx_data} == '0) begin
                        o_core_restart <= 1'b1;   // Empty program
                        state          <= S_IDLE;
                    end else begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: if (i_rx_done) begin
                    imem.addr               <= byte_idx[2 +: dbg_pkg::NB_IMEM_ADDR];
                    imem.lane_sel           <= '0;
                    imem.lane_sel[byte_idx[1:0]] <= 1'b1;
                    imem.data               <= i_rx_data;
                    imem.write              <= (byte_idx < IMEM_BYTES);  // Drop overflow
                    byte_idx                <= byte_idx + 1'b1;
                    if (byte_idx == size - 1'b1) begin
                        o_core_restart <= 1'b1;   // Lines up with the last write
                        state          <= S_IDLE;
                    end
                end
                S_RUN: if (i_halted) begin
                    state <= S_IDLE;
                end
                S_READ: state <= S_START;
                S_START: begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= tx_byte;
                    state      <= S_WAIT_TX;
                end
                S_WAIT_TX: if (i_tx_done) begin
                    state <= S_READ;
                    if (!last_byte) begin
                        byte_pos <= byte_pos + 1'b1;
                    end else begin
                        byte_pos <= '0;
                        if (last_item) begin
                            state <= S_IDLE;
                        end else if (dump_sel == SEL_RB) begin
                            rb_idx <= rb_idx + 1'b1;
                        end else begin
                            dm_addr <= dm_addr + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign o_core_run = (state == S_RUN);
    assign o_rb_addr  = rb_idx;
    assign o_dm_addr  = dm_addr;

endmodule

// ==== hw/debug_top.sv ====
`timescale 1ns/1ns

module debug_top #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx_done,
    input  logic [dbg_pkg::NB_DATA-1:0] i_rx_data,
    input  logic                        i_tx_done,
    output logic                        o_tx_start,
    output logic [dbg_pkg::NB_DATA-1:0] o_tx_data,
    output logic                        o_halted
);

    imem_wr_if imem_wr ();

    logic [dbg_pkg::NB_DATA-1:0]      lane_data [dbg_pkg::N_LANES];
    dbg_pkg::inst_word_t              inst;
    logic [dbg_pkg::NB_IMEM_ADDR-1:0] fetch_addr;
    logic [dbg_pkg::NB_IMEM_ADDR-1:0] pc;
    logic                             core_run;
    logic                             core_step;
    logic                             core_restart;

    // Register bank, core side and debug side
    logic [dbg_pkg::NB_RB_ADDR-1:0] core_rb_rd_addr;
    logic [dbg_pkg::NB_WORD-1:0]    core_rb_rd_data;
    logic                           rb_wr_en;
    logic [dbg_pkg::NB_RB_ADDR-1:0] rb_wr_addr;
    logic [dbg_pkg::NB_WORD-1:0]    rb_wr_data;
    logic [dbg_pkg::NB_RB_ADDR-1:0] dbg_rb_addr;
    logic [dbg_pkg::NB_WORD-1:0]    dbg_rb_data;

    // Data memory
    logic                           dm_wr_en;
    logic [dbg_pkg::NB_DM_ADDR-1:0] dm_wr_addr;
    logic [dbg_pkg::NB_DATA-1:0]    dm_wr_data;
    logic [dbg_pkg::NB_DM_ADDR-1:0] dbg_dm_addr;
    logic [dbg_pkg::NB_DATA-1:0]    dbg_dm_data;

    for (genvar g = 0; g < dbg_pkg::N_LANES; g++) begin : g_lane
        imem_lane #(
            .IMEM_DEPTH (IMEM_DEPTH),
            .LANE       (g)
        ) u_lane (
            .i_clock   (i_clock),
            .wr        (imem_wr.lane),
            .i_rd_addr (fetch_addr),
            .o_rd_data (lane_data[g])
        );
    end

    // Lane 0 holds the first program byte of each word
    always_comb begin
        for (int i = 0; i < dbg_pkg::N_LANES; i++) begin
            inst.bytes[i] = lane_data[i];
        end
    end

    debug_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_debug (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_rx_done      (i_rx_done),
        .i_rx_data      (i_rx_data),
        .i_tx_done      (i_tx_done),
        .o_tx_start     (o_tx_start),
        .o_tx_data      (o_tx_data),
        .imem           (imem_wr.loader),
        .o_core_run     (core_run),
        .o_core_step    (core_step),
        .o_core_restart (core_restart),
        .i_halted       (o_halted),
        .i_pc           (pc),
        .o_rb_addr      (dbg_rb_addr),
        .i_rb_data      (dbg_rb_data),
        .o_dm_addr      (dbg_dm_addr),
        .i_dm_data      (dbg_dm_data)
    );

    exec_core #(.IMEM_DEPTH(IMEM_DEPTH)) u_core (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_run        (core_run),
        .i_step       (core_step),
        .i_restart    (core_restart),
        .i_inst       (inst),
        .o_fetch_addr (fetch_addr),
        .o_rb_rd_addr (core_rb_rd_addr),
        .i_rb_rd_data (core_rb_rd_data),
        .o_rb_wr_en   (rb_wr_en),
        .o_rb_wr_addr (rb_wr_addr),
        .o_rb_wr_data (rb_wr_data),
        .o_dm_wr_en   (dm_wr_en),
        .o_dm_wr_addr (dm_wr_addr),
        .o_dm_wr_data (dm_wr_data),
        .o_pc         (pc),
        .o_halted     (o_halted)
    );

    reg_bank u_reg_bank (
        .i_clock    (i_clock),
        .i_wr_en    (rb_wr_en),
        .i_wr_addr  (rb_wr_addr),
        .i_wr_data  (rb_wr_data),
        .i_rd_addr  (core_rb_rd_addr),
        .o_rd_data  (core_rb_rd_data),
        .i_dbg_addr (dbg_rb_addr),
        .o_dbg_data (dbg_rb_data)
    );

    data_mem u_data_mem (
        .i_clock    (i_clock),
        .i_wr_en    (dm_wr_en),
        .i_wr_addr  (dm_wr_addr),
        .i_wr_data  (dm_wr_data),
        .i_dbg_addr (dbg_dm_addr),
        .o_dbg_data (dbg_dm_data)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2) o_clock = ~o_clock;
    end

endmodule

// ==== sim/tb_debug_top.sv ====
`timescale 1ns/1ns

module tb_debug_top;

    localparam int IMEM_DEPTH = 64;
    // About 660 dump bytes at up to 8 cycles each plus loads, runs and steps
    // with a wide margin on top
    localparam int TIMEOUT_CYCLES = 200_000;

    logic       clock;
    logic       i_reset;
    logic       i_rx_done;
    logic [7:0] i_rx_data;
    logic       i_tx_done;
    logic       o_tx_start;
    logic [7:0] o_tx_data;
    logic       o_halted;

    logic [31:0] lfsr;
    int          cycle_count = 0;
    logic [7:0]  tx_bytes [$];    // Bytes seen on o_tx_data
    logic [31:0] prog [$];        // Program being built

    // Reference model
    logic [31:0] m_imem [IMEM_DEPTH];
    logic [31:0] m_regs [32];
    logic [7:0]  m_dm [128];
    int          m_pc;
    logic        m_halted;

    tb_clock #(.PERIOD_NS(8)) u_clock (.o_clock(clock));

    debug_top #(.IMEM_DEPTH(IMEM_DEPTH)) uut (
        .i_clock    (clock),
        .i_reset    (i_reset),
        .i_rx_done  (i_rx_done),
        .i_rx_data  (i_rx_data),
        .i_tx_done  (i_tx_done),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .o_halted   (o_halted)
    );

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    function automatic logic [31:0] make_inst(input logic [7:0] op, input int rd,
                                              input logic [31:0] imm);
        return {op, 3'b000, rd[4:0], imm[15:0]};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Moves to 1 ns after the next rising edge
    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_quiet(input int n);
        repeat (n) begin
            tick();
            check_eq("o_tx_start", {31'b0, o_tx_start}, 32'd0);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        i_rx_done = 1'b1;
        i_rx_data = b;
        tick();
        i_rx_done = 1'b0;
    endtask

    // Host side of the serializer with a random 1 to 4 cycle delay before done
    task automatic collect_tx(input int n);
        int delay;
        tx_bytes.delete();
        while (tx_bytes.size() < n) begin
            tick();
            if (o_tx_start) begin
                tx_bytes.push_back(o_tx_data);
                delay = rand_bits(2) + 1;
                repeat (delay) tick();
                check_eq("o_tx_data", {24'b0, o_tx_data}, {24'b0, tx_bytes[$]});
                i_tx_done = 1'b1;
                tick();
                i_tx_done = 1'b0;
            end
        end
        wait_quiet(3);    // No extra bytes
    endtask

    task automatic model_step();
        logic [31:0] inst;
        if (!m_halted) begin
            inst = m_imem[m_pc];
            case (inst[31:24])
                dbg_pkg::OP_LI:   m_regs[inst[20:16]] = {16'b0, inst[15:0]};
                dbg_pkg::OP_SB:   m_dm[inst[6:0]] = m_regs[inst[20:16]][7:0];
                dbg_pkg::OP_HALT: m_halted = 1'b1;
                default:          ;
            endcase
            if (!m_halted) begin
                m_pc = (m_pc + 1) % IMEM_DEPTH;
            end
        end
    endtask

    task automatic load_program();
        int n_bytes;
        n_bytes = prog.size() * 4;
        send_byte(dbg_pkg::CMD_LOAD);
        send_byte(n_bytes[15:8]);
        send_byte(n_bytes[7:0]);
        foreach (prog[w]) begin
            for (int b = 3; b >= 0; b--) begin
                send_byte(prog[w][b*8 +: 8]);    // MSB first
            end
            m_imem[w] = prog[w];
        end
        m_pc     = 0;
        m_halted = 1'b0;
        wait_quiet(4);
        check_eq("o_halted", {31'b0, o_halted}, 32'd0);
    endtask

    task automatic expect_pc();
        logic [31:0] exp;
        exp = m_pc;
        send_byte(dbg_pkg::CMD_SEND_PC);
        collect_tx(4);
        for (int i = 0; i < 4; i++) begin
            check_eq($sformatf("o_tx_data pc byte %0d", i), {24'b0, tx_bytes[i]},
                     {24'b0, exp[31 - 8*i -: 8]});
        end
    endtask

    task automatic run_to_halt();
        send_byte(dbg_pkg::CMD_RUN);
        send_byte(dbg_pkg::CMD_SEND_PC);    // Must be dropped while running
        while (!o_halted) begin
            tick();
            check_eq("o_tx_start", {31'b0, o_tx_start}, 32'd0);
        end
        wait_quiet(3);
        repeat (4 * IMEM_DEPTH) model_step();
        expect_pc();    // PC rests on the halt instruction
    endtask

    task automatic expect_regs();
        send_byte(dbg_pkg::CMD_DUMP_RB);
        collect_tx(128);
        for (int r = 0; r < 32; r++) begin
            for (int i = 0; i < 4; i++) begin
                check_eq($sformatf("o_tx_data reg %0d byte %0d", r, i),
                         {24'b0, tx_bytes[r*4 + i]}, {24'b0, m_regs[r][31 - 8*i -: 8]});
            end
        end
    endtask

    task automatic expect_dm();
        send_byte(dbg_pkg::CMD_DUMP_DM);
        collect_tx(128);
        for (int a = 0; a < 128; a++) begin
            check_eq($sformatf("o_tx_data dm %0d", a), {24'b0, tx_bytes[a]},
                     {24'b0, m_dm[a]});
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          rd;
        int          addr;

        i_reset   = 1'b1;
        i_rx_done = 1'b0;
        i_rx_data = 8'h00;
        i_tx_done = 1'b0;
        lfsr      = 32'hc09c;
        m_pc      = 0;
        m_halted  = 1'b0;
        repeat (8) tick();
        i_reset = 1'b0;

        // Quiet after reset and the PC reads back as zero
        repeat (20) begin
            tick();
            check_eq("o_tx_start", {31'b0, o_tx_start}, 32'd0);
            check_eq("o_halted", {31'b0, o_halted}, 32'd0);
        end
        expect_pc();

        // One load immediate per register
        prog.delete();
        for (int r = 0; r < 32; r++) begin
            prog.push_back(make_inst(dbg_pkg::OP_LI, r, rand_bits(16)));
        end
        prog.push_back(make_inst(dbg_pkg::OP_HALT, 0, 0));
        load_program();
        run_to_halt();
        expect_regs();

        // Eight programs of 16 stores each cover all of data memory
        for (int blk = 0; blk < 8; blk++) begin
            prog.delete();
            for (int j = 0; j < 16; j++) begin
                if (rand_bits(1) == 32'd1) begin
                    rd = rand_bits(5);
                    prog.push_back(make_inst(dbg_pkg::OP_LI, rd, rand_bits(16)));
                end
                rd   = rand_bits(5);
                rnd  = rand_bits(9);     // Upper immediate bits are ignored
                addr = blk * 16 + j;
                prog.push_back(make_inst(dbg_pkg::OP_SB, rd, {16'b0, rnd[8:0], addr[6:0]}));
            end
            prog.push_back(make_inst(dbg_pkg::OP_HALT, 0, 0));
            load_program();
            run_to_halt();
        end
        expect_dm();

        // Single steps through no-ops and loads up to the halt
        prog.delete();
        for (int k = 0; k < 24; k++) begin
            rd = rand_bits(5);
            if (rand_bits(1) == 32'd1) begin
                prog.push_back(make_inst(dbg_pkg::OP_LI, rd, rand_bits(16)));
            end else begin
                do begin
                    rnd = rand_bits(8);
                end while (rnd[7:0] inside {dbg_pkg::OP_LI, dbg_pkg::OP_SB, dbg_pkg::OP_HALT});
                prog.push_back(make_inst(rnd[7:0], rd, rand_bits(16)));
            end
        end
        prog.push_back(make_inst(dbg_pkg::OP_HALT, 0, 0));
        load_program();
        for (int k = 0; k < 25; k++) begin
            send_byte(dbg_pkg::CMD_STEP);
            wait_quiet(4);
            model_step();
            expect_pc();
        end
        check_eq("o_halted", {31'b0, o_halted}, {31'b0, m_halted});
        expect_regs();

        // Halted core ignores run and step
        send_byte(dbg_pkg::CMD_RUN);
        wait_quiet(4);
        send_byte(dbg_pkg::CMD_STEP);
        wait_quiet(4);
        model_step();
        expect_pc();
        repeat (8) begin
            do begin
                rnd = rand_bits(8);
            end while (rnd[7:0] inside {dbg_pkg::CMD_LOAD, dbg_pkg::CMD_RUN,
                                        dbg_pkg::CMD_STEP, dbg_pkg::CMD_DUMP_RB,
                                        dbg_pkg::CMD_SEND_PC, dbg_pkg::CMD_DUMP_DM});
            send_byte(rnd[7:0]);
            wait_quiet(4);
        end
        check_eq("o_halted", {31'b0, o_halted}, 32'd1);
        expect_regs();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== debug_top.f ====
hw/dbg_pkg.sv
hw/imem_wr_if.sv
hw/imem_lane.sv
hw/reg_bank.sv
hw/data_mem.sv
hw/exec_core.sv
hw/debug_unit.sv
hw/debug_top.sv
sim/tb_clock.sv
sim/tb_debug_top.sv

// ==== Makefile ====
TOP = tb_debug_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module debug_top -f debug_top.f

sim:
	verilator --binary --timing --top-module $(TOP) -f debug_top.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
